//--- design/cnnPkg.sv
`default_nettype none

package cnnPkg;

    parameter int DataWidth = 16;

    typedef logic signed [DataWidth-1:0] word_t;

    // addresses travel at full word width, each module wraps them to its AddrWidth
    typedef logic [DataWidth-1:0] addr_t;

    typedef struct packed {
        logic       convLayer;
        logic [3:0] filterSize;
        logic [7:0] filterCount;
    } layerDesc_t;

    typedef struct packed {
        addr_t      mapAddr;
        logic [7:0] mapSize;
        logic [7:0] mapCount;
    } mapState_t;

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t writeData;
    } memReq_t;

    typedef enum logic [1:0] {ownerHost, ownerSequencer, ownerConv, ownerPool} memOwner_t;

endpackage

`default_nettype wire

//--- design/configRegs.sv
`timescale 1ns/1ns
`default_nettype none

module configRegs import cnnPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       regWrite,
    input  logic [1:0] regAddr,
    input  word_t      regData,
    input  logic       started,
    input  logic       finished,
    input  logic [7:0] layersDone,
    output logic       go,
    output addr_t      layerBase,
    output mapState_t  initialMaps,
    output logic       busy,
    output logic       done,
    output logic [7:0] layerCount
);

    logic       hostWrite;
    addr_t      imageBase;
    logic [7:0] imageSize;

    // configuration is frozen while a network runs
    assign hostWrite = regWrite && !busy;
    assign go = hostWrite && regAddr == 2'd3;

    // the first layer always sees a single input map
    assign initialMaps = '{mapAddr: imageBase, mapSize: imageSize, mapCount: 8'd1};

    always_ff @(posedge clk) begin
        if (reset) begin
            layerBase <= '0;
            imageBase <= '0;
            imageSize <= '0;
        end else if (hostWrite) begin
            case (regAddr)
                2'd0: layerBase <= addr_t'(regData);
                2'd1: imageBase <= addr_t'(regData);
                2'd2: imageSize <= regData[7:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            layerCount <= '0;
        end else begin
            if (go) begin
                busy <= 1'b1;
                done <= 1'b0;
            end
            if (started) layerCount <= '0;
            // done holds until the next start
            if (finished) begin
                busy       <= 1'b0;
                done       <= 1'b1;
                layerCount <= layersDone;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/scratchpad.sv
`timescale 1ns/1ns
`default_nettype none

module scratchpad import cnnPkg::*; #(
    parameter int AddrWidth = 12
) (
    input  logic      clk,
    input  memOwner_t owner,
    input  memReq_t   hostReq,
    input  memReq_t   seqReq,
    input  memReq_t   convReq,
    input  memReq_t   poolReq,
    output word_t     readData
);

    word_t   mem [2**AddrWidth];
    memReq_t req;

    // only the current owner reaches the array
    always_comb begin
        case (owner)
            ownerSequencer: req = seqReq;
            ownerConv:      req = convReq;
            ownerPool:      req = poolReq;
            default:        req = hostReq;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req.write) mem[req.addr[AddrWidth-1:0]] <= req.writeData;
        if (req.read) readData <= mem[req.addr[AddrWidth-1:0]];
    end

endmodule

`default_nettype wire

//--- design/layerSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module layerSequencer import cnnPkg::*; #(
    parameter int AddrWidth = 12
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       go,
    input  addr_t      layerBase,
    input  mapState_t  initialMaps,
    input  word_t      readData,
    input  logic       convFinished,
    input  logic       poolFinished,
    output memOwner_t  owner,
    output memReq_t    seqReq,
    output logic       convRun,
    output logic       poolRun,
    output layerDesc_t layer,
    output mapState_t  maps,
    output addr_t      weightAddr,
    output logic       started,
    output logic       finished,
    output logic [7:0] layersDone
);

    localparam addr_t AddrMask = addr_t'((1 << AddrWidth) - 1);

    typedef enum logic [2:0] {sIdle, sCount, sCountWait, sDesc, sRun, sWait} seqState_t;

    seqState_t  state;
    addr_t      descAddr;
    logic [1:0] descIdx;
    logic [7:0] layerTotal;
    addr_t      mapWords;
    addr_t      weightWords;

    assign mapWords = addr_t'(maps.mapCount) * addr_t'(maps.mapSize) * addr_t'(maps.mapSize);
    assign weightWords = addr_t'(layer.filterCount) * addr_t'(layer.filterSize)
                       * addr_t'(layer.filterSize);

    // weights follow the three descriptor words
    assign weightAddr = (descAddr + addr_t'(3)) & AddrMask;
    assign convRun = state == sRun && layer.convLayer;
    assign poolRun = state == sRun && !layer.convLayer;

    always_comb begin
        case (state)
            sIdle:                    owner = ownerHost;
            sCount, sCountWait, sDesc: owner = ownerSequencer;
            default:                  owner = layer.convLayer ? ownerConv : ownerPool;
        endcase
    end

    always_comb begin
        seqReq.read      = state == sCount || (state == sDesc && descIdx != 2'd3);
        seqReq.write     = 1'b0;
        seqReq.addr      = (descAddr + addr_t'(descIdx)) & AddrMask;
        seqReq.writeData = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= sIdle;
            descIdx    <= '0;
            started    <= 1'b0;
            finished   <= 1'b0;
            layersDone <= '0;
        end else begin
            started  <= 1'b0;
            finished <= 1'b0;
            case (state)
                sIdle: begin
                    if (go) begin
                        descAddr   <= layerBase & AddrMask;
                        maps       <= initialMaps;
                        descIdx    <= '0;
                        layersDone <= '0;
                        started    <= 1'b1;
                        state      <= sCount;
                    end
                end
                sCount: state <= sCountWait;
                sCountWait: begin
                    layerTotal <= readData[7:0];
                    descAddr   <= (descAddr + addr_t'(1)) & AddrMask;
                    if (readData[7:0] == 8'd0) begin
                        finished <= 1'b1;
                        state    <= sIdle;
                    end else begin
                        state <= sDesc;
                    end
                end
                sDesc: begin
                    // each word arrives one cycle after its read, idx wraps back to 0
                    descIdx <= descIdx + 2'd1;
                    case (descIdx)
                        2'd1: layer.convLayer <= readData[0];
                        2'd2: layer.filterSize <= readData[3:0];
                        2'd3: begin
                            layer.filterCount <= readData[7:0];
                            state             <= sRun;
                        end
                        default: ;
                    endcase
                end
                sRun: state <= sWait;
                default: begin
                    if (convFinished || poolFinished) begin
                        layersDone   <= layersDone + 8'd1;
                        maps.mapAddr <= (maps.mapAddr + mapWords) & AddrMask;
                        if (layer.convLayer) begin
                            descAddr      <= (descAddr + addr_t'(3) + weightWords) & AddrMask;
                            maps.mapSize  <= maps.mapSize - 8'(layer.filterSize) + 8'd1;
                            maps.mapCount <= layer.filterCount;
                        end else begin
                            descAddr     <= (descAddr + addr_t'(3)) & AddrMask;
                            maps.mapSize <= maps.mapSize >> 1;
                        end
                        if (layersDone + 8'd1 == layerTotal) begin
                            finished <= 1'b1;
                            state    <= sIdle;
                        end else begin
                            state <= sDesc;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/convEngine.sv
`timescale 1ns/1ns
`default_nettype none

module convEngine import cnnPkg::*; #(
    parameter int AddrWidth = 12
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  layerDesc_t layer,
    input  mapState_t  maps,
    input  addr_t      weightAddr,
    input  word_t      readData,
    output memReq_t    convReq,
    output logic       finished
);

    localparam addr_t AddrMask = addr_t'((1 << AddrWidth) - 1);

    logic       active;
    logic [1:0] phase;
    logic       havePair;
    logic [7:0] filter, row, col, mapIdx;
    logic [3:0] wi, wj;
    word_t      imgReg, acc;
    addr_t      outAddr, area, imgAddr, wgtAddr;
    logic [7:0] outSize;
    logic       lastWin, lastMac, lastPixel;

    assign outSize = maps.mapSize - 8'(layer.filterSize) + 8'd1;
    assign area = addr_t'(maps.mapSize) * addr_t'(maps.mapSize);
    assign imgAddr = (maps.mapAddr + addr_t'(mapIdx) * area
                   + addr_t'(row + 8'(wi)) * addr_t'(maps.mapSize)
                   + addr_t'(col + 8'(wj))) & AddrMask;
    assign wgtAddr = (weightAddr
                   + addr_t'(filter) * addr_t'(layer.filterSize) * addr_t'(layer.filterSize)
                   + addr_t'(wi) * addr_t'(layer.filterSize) + addr_t'(wj)) & AddrMask;

    assign lastWin = wi == layer.filterSize - 4'd1 && wj == layer.filterSize - 4'd1;
    assign lastMac = lastWin && mapIdx == maps.mapCount - 8'd1;
    assign lastPixel = row == outSize - 8'd1 && col == outSize - 8'd1;

    // phase 0 reads image, 1 reads weight, 2 writes the finished sum
    always_comb begin
        convReq.read      = active && phase != 2'd2;
        convReq.write     = active && phase == 2'd2;
        convReq.addr      = phase == 2'd1 ? wgtAddr : (phase == 2'd2 ? outAddr : imgAddr);
        convReq.writeData = acc + imgReg * readData;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            phase    <= '0;
            havePair <= 1'b0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (run) begin
                active   <= 1'b1;
                phase    <= '0;
                havePair <= 1'b0;
                {filter, row, col, mapIdx, wi, wj} <= '0;
                outAddr  <= (maps.mapAddr + addr_t'(maps.mapCount) * area) & AddrMask;
            end else if (active) begin
                case (phase)
                    2'd0: begin
                        // previous product lands while the next image word is fetched
                        acc   <= havePair ? acc + imgReg * readData : '0;
                        phase <= 2'd1;
                    end
                    2'd1: begin
                        imgReg   <= readData;
                        havePair <= 1'b1;
                        phase    <= lastMac ? 2'd2 : 2'd0;
                        if (lastWin) begin
                            wi     <= '0;
                            wj     <= '0;
                            mapIdx <= mapIdx + 8'd1;
                        end else if (wj == layer.filterSize - 4'd1) begin
                            wj <= '0;
                            wi <= wi + 4'd1;
                        end else begin
                            wj <= wj + 4'd1;
                        end
                    end
                    default: begin
                        havePair <= 1'b0;
                        phase    <= '0;
                        mapIdx   <= '0;
                        outAddr  <= (outAddr + addr_t'(1)) & AddrMask;
                        if (lastPixel) begin
                            row <= '0;
                            col <= '0;
                            if (filter == layer.filterCount - 8'd1) begin
                                active   <= 1'b0;
                                finished <= 1'b1;
                            end else begin
                                filter <= filter + 8'd1;
                            end
                        end else if (col == outSize - 8'd1) begin
                            col <= '0;
                            row <= row + 8'd1;
                        end else begin
                            col <= col + 8'd1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/poolEngine.sv
`timescale 1ns/1ns
`default_nettype none

module poolEngine import cnnPkg::*; #(
    parameter int AddrWidth = 12
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  mapState_t maps,
    input  word_t     readData,
    output memReq_t   poolReq,
    output logic      finished
);

    localparam addr_t AddrMask = addr_t'((1 << AddrWidth) - 1);

    logic       active;
    logic [2:0] phase;
    logic [7:0] mapIdx, row, col;
    logic [7:0] outSize;
    word_t      best, larger;
    addr_t      area, inBase, outAddr, rdAddr;

    // odd last row and column fall out of the rounding
    assign outSize = maps.mapSize >> 1;
    assign area = addr_t'(maps.mapSize) * addr_t'(maps.mapSize);
    assign rdAddr = (inBase + addr_t'({row, phase[1]}) * addr_t'(maps.mapSize)
                  + addr_t'({col, phase[0]})) & AddrMask;
    assign larger = readData > best ? readData : best;

    // phases 0..3 read the window, 4 writes its maximum
    always_comb begin
        poolReq.read      = active && phase < 3'd4;
        poolReq.write     = active && phase == 3'd4;
        poolReq.addr      = phase == 3'd4 ? outAddr : rdAddr;
        poolReq.writeData = larger;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            phase    <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (run) begin
                active  <= outSize != 8'd0 && maps.mapCount != 8'd0;
                finished <= outSize == 8'd0 || maps.mapCount == 8'd0;
                phase   <= '0;
                {mapIdx, row, col} <= '0;
                inBase  <= maps.mapAddr & AddrMask;
                outAddr <= (maps.mapAddr + addr_t'(maps.mapCount) * area) & AddrMask;
            end else if (active) begin
                phase <= phase == 3'd4 ? 3'd0 : phase + 3'd1;
                if (phase == 3'd1) best <= readData;
                if (phase == 3'd2 || phase == 3'd3) best <= larger;
                if (phase == 3'd4) begin
                    outAddr <= (outAddr + addr_t'(1)) & AddrMask;
                    if (col != outSize - 8'd1) begin
                        col <= col + 8'd1;
                    end else begin
                        col <= '0;
                        if (row != outSize - 8'd1) begin
                            row <= row + 8'd1;
                        end else begin
                            row <= '0;
                            if (mapIdx == maps.mapCount - 8'd1) begin
                                active   <= 1'b0;
                                finished <= 1'b1;
                            end else begin
                                mapIdx <= mapIdx + 8'd1;
                                inBase <= (inBase + area) & AddrMask;
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cnnAccel.sv
`timescale 1ns/1ns
`default_nettype none

module cnnAccel import cnnPkg::*; #(
    parameter int AddrWidth = 12
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       regWrite,
    input  logic [1:0] regAddr,
    input  word_t      regData,
    input  logic       memWrite,
    input  logic       memRead,
    input  addr_t      memAddr,
    input  word_t      memData,
    output word_t      memReadData,
    output logic       busy,
    output logic       done,
    output logic [7:0] layerCount
);

    logic       go, started, finished, convRun, poolRun, convFinished, poolFinished;
    logic [7:0] layersDone;
    addr_t      layerBase, weightAddr;
    mapState_t  initialMaps, maps;
    layerDesc_t layer;
    memOwner_t  owner;
    memReq_t    hostReq, seqReq, convReq, poolReq;
    word_t      readData;

    // host traffic is dropped while a network runs
    assign hostReq = '{read: memRead && !busy, write: memWrite && !busy,
                       addr: memAddr, writeData: memData};
    assign memReadData = readData;

    configRegs u_configRegs (
        .clk, .reset, .regWrite, .regAddr, .regData, .started, .finished, .layersDone,
        .go, .layerBase, .initialMaps, .busy, .done, .layerCount
    );

    layerSequencer #(.AddrWidth(AddrWidth)) u_layerSequencer (
        .clk, .reset, .go, .layerBase, .initialMaps, .readData, .convFinished, .poolFinished,
        .owner, .seqReq, .convRun, .poolRun, .layer, .maps, .weightAddr, .started,
        .finished, .layersDone
    );

    convEngine #(.AddrWidth(AddrWidth)) u_convEngine (
        .clk, .reset, .run(convRun), .layer, .maps, .weightAddr, .readData,
        .convReq, .finished(convFinished)
    );

    poolEngine #(.AddrWidth(AddrWidth)) u_poolEngine (
        .clk, .reset, .run(poolRun), .maps, .readData, .poolReq, .finished(poolFinished)
    );

    scratchpad #(.AddrWidth(AddrWidth)) u_scratchpad (
        .clk, .owner, .hostReq, .seqReq, .convReq, .poolReq, .readData
    );

endmodule

`default_nettype wire

//--- bench/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/cnnBench.sv
`timescale 1ns/1ns
`default_nettype none

module cnnBench import cnnPkg::*; ();

    logic        clk;
    logic        reset;
    logic        regWrite;
    logic [1:0]  regAddr;
    word_t       regData;
    logic        memWrite;
    logic        memRead;
    addr_t       memAddr;
    word_t       memData;
    word_t       memReadData;
    logic        busy;
    logic        done;
    logic [7:0]  layerCount;

    logic [15:0] testData [1024];
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int          errorCount = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          seed = 15495;

    clockGen u_clockGen (.clk, .reset);

    cnnAccel #(.AddrWidth(12)) u_cnnAccel (
        .clk, .reset, .regWrite, .regAddr, .regData, .memWrite, .memRead, .memAddr,
        .memData, .memReadData, .busy, .done, .layerCount
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the accelerator never reported done",
                     cycleCount);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic logError(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errorCount++;
    endtask

    task automatic writeWord(input addr_t addr, input word_t data);
        @(posedge clk);
        memWrite <= 1'b1;
        memAddr  <= addr;
        memData  <= data;
    endtask

    task automatic endWrites();
        @(posedge clk);
        memWrite <= 1'b0;
    endtask

    task automatic writeReg(input logic [1:0] addr, input logic [15:0] data);
        @(posedge clk);
        regWrite <= 1'b1;
        regAddr  <= addr;
        regData  <= data;
        @(posedge clk);
        regWrite <= 1'b0;
    endtask

    // read data shows up one cycle after the strobe
    task automatic readWord(input addr_t addr, output word_t data);
        @(posedge clk);
        memRead <= 1'b1;
        memAddr <= addr;
        @(posedge clk);
        memRead <= 1'b0;
        @(negedge clk);
        data = memReadData;
    endtask

    task automatic runTest(input int testNum, inout int ptr);
        addr_t      loadBase;
        int         loadCount;
        logic       busyWrites;
        logic [7:0] expLayers;
        addr_t      expBase;
        int         expCount;
        word_t      got;
        int         errorsBefore;
        int         i;
        errorsBefore = errorCount;
        loadBase     = testData[ptr];
        loadCount    = int'(testData[ptr+1]);
        busyWrites   = testData[ptr+3][0];
        for (i = 0; i < loadCount; i++) begin
            writeWord(loadBase + addr_t'(i), testData[ptr+4+i]);
        end
        endWrites();
        ptr += 4 + loadCount;
        writeReg(2'd0, testData[ptr]);
        writeReg(2'd1, testData[ptr+1]);
        writeReg(2'd2, testData[ptr+2]);
        expLayers = testData[ptr+3][7:0];
        expBase   = testData[ptr+4];
        expCount  = int'(testData[ptr+5]);
        ptr += 6;
        writeReg(2'd3, 16'h0001);
        @(negedge clk);
        if (busy !== 1'b1) logError("busy not high one cycle after start");
        // these writes land while the network runs and must be dropped
        if (busyWrites) begin
            for (i = 0; i < expCount; i++) begin
                writeWord(expBase + addr_t'(i), word_t'($random(seed)));
            end
            endWrites();
        end
        while (done !== 1'b1) @(negedge clk);
        if (busy !== 1'b0) logError("busy still high while done is high");
        if (layerCount !== expLayers) begin
            logError($sformatf("layerCount is %0d, expected %0d", layerCount, expLayers));
        end
        for (i = 0; i < expCount; i++) begin
            readWord(expBase + addr_t'(i), got);
            if (got !== word_t'(testData[ptr+i])) begin
                logError($sformatf("word at %h reads %h, expected %h",
                                   expBase + addr_t'(i), got, testData[ptr+i]));
            end
        end
        ptr += expCount;
        if (errorCount == errorsBefore) begin
            $display("test %0d: pass", testNum);
            passCount++;
        end else begin
            $display("test %0d: FAIL with %0d errors", testNum, errorCount - errorsBefore);
            failCount++;
        end
    endtask

    initial begin
        int ptr;
        int numTests;
        int totalWords;
        int maxReads;
        int t;
        regWrite = 1'b0;
        regAddr  = '0;
        regData  = '0;
        memWrite = 1'b0;
        memRead  = 1'b0;
        memAddr  = '0;
        memData  = '0;
        $readmemh("bench/cnnTestdata.txt", testData);
        numTests = int'(testData[0]);
        // one pass over the records to size the timeout
        ptr        = 1;
        totalWords = 0;
        maxReads   = 0;
        for (t = 0; t < numTests; t++) begin
            if (int'(testData[ptr+2]) > maxReads) maxReads = int'(testData[ptr+2]);
            ptr += 4 + int'(testData[ptr+1]);
            totalWords += int'(testData[ptr+5]);
            ptr += 6 + int'(testData[ptr+5]);
        end
        cycleLimit = 4 * totalWords * maxReads + 200 * numTests;
        @(negedge clk);
        while (reset) @(negedge clk);
        if (busy !== 1'b0 || done !== 1'b0 || layerCount !== 8'd0) begin
            logError($sformatf("after reset busy=%b done=%b layerCount=%0d, expected zeros",
                               busy, done, layerCount));
        end
        ptr = 1;
        for (t = 1; t <= numTests; t++) runTest(t, ptr);
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cnnAccel.f
design/cnnPkg.sv
design/configRegs.sv
design/scratchpad.sv
design/layerSequencer.sv
design/convEngine.sv
design/poolEngine.sv
design/cnnAccel.sv
bench/clockGen.sv
bench/cnnBench.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the cnnBench testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns -f cnnAccel.f --top-module cnnBench -Mdir obj_dir
	./obj_dir/VcnnBench | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/cnnTestdata.txt
// first word is the test count, then per test:
// loadBase loadCount readsPerOutputWord busyWrites, then loadCount memory words
// layerBase imageBase imageSize expectedLayerCount, expectedBase expectedCount, expected words
0006
// test 1: zero layers
0010 0001 0000 0000
0000
0010 0011 0000 0000
0011 0000
// test 2: one 2x2 pool on a 4x4 map
0040 0014 0004 0000
0001 0000 0000 0000
0003 FFFE 0007 0001 FFF0 0005 FFFF FFFC
FFF8 FFF9 0000 000A FFFA FFFB 0002 FFF5
0040 0044 0004 0001
0054 0004
0005 0007 FFFB 000A
// test 3: 3x3 conv with two filters on a 5x5 map, second filter wraps
0100 002F 0012 0000
0001 0001 0003 0002
0001 0002 0000 0000 FFFF 0000 0000 0000 0003
0001 0000 0000 0000 4000 0000 0000 0000 0000
0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D
000E 000F 0010 0011 0012 0013 0014 0015 0016 0017 0018 0019
0100 0116 0005 0001
012F 0012
0025 002A 002F 003E 0043 0048 0057 005C 0061
C001 0002 4003 0006 4007 8008 400B 800C C00D
// test 4: conv then pool, pooled maps follow the conv output
0200 0029 0012 0000
0002 0001 0003 0002
0001 0001 0001 0001 0001 0001 0001 0001 0001
0000 0000 FFFE 0000 FFFF 0000 0000 0000 0000
0000 0000 0000
0001 0002 0003 0004 0005 0006 0007 0008
0009 000A 000B 000C 000D 000E 000F 0010
0200 0219 0004 0002
0229 000A
0036 003F 005A 0063 FFF4 FFF1 FFE8 FFE5 0063 FFF4
// test 5: host writes while busy, input and output must be untouched
0300 0014 0004 0001
0001 0000 0000 0000
0010 0020 FF00 FF01 0030 0005 FF02 FF03
7FFF 8000 0001 0002 0000 FFFF 0003 0004
0300 0304 0004 0001
0304 0014
0010 0020 FF00 FF01 0030 0005 FF02 FF03
7FFF 8000 0001 0002 0000 FFFF 0003 0004
0030 FF03 7FFF 0004
// test 6: pool on a 5x5 map drops the last row and column
0400 001D 0004 0000
0001 0000 0000 0000
0001 0002 0003 0004 7000 0005 0006 0007 0008 7001
0009 000A 000B 000C 7002 000D 000E 000F 0010 7003
7004 7005 7006 7007 7008
0400 0404 0005 0001
041D 0004
0006 0008 000E 0010
